// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Data and instruction widths.
    localparam int xlen      = 32;
    localparam int ilen      = 32;
    localparam int reg_idx_w = 5;
    localparam int cause_w   = 4;

    // Instruction field widths.
    localparam int opcode_w  = 5;
    localparam int funct3_w  = 3;
    localparam int funct12_w = 12;

    // Major opcodes, instruction bits 6 to 2.
    typedef enum logic [opcode_w-1:0] {
        op_load     = 5'b00000,
        op_misc_mem = 5'b00011,
        op_op_imm   = 5'b00100,
        op_auipc    = 5'b00101,
        op_store    = 5'b01000,
        op_op       = 5'b01100,
        op_lui      = 5'b01101,
        op_branch   = 5'b11000,
        op_jalr     = 5'b11001,
        op_jal      = 5'b11011,
        op_system   = 5'b11100
    } opcode_e;

    // ALU funct3 values that carry extra encoding rules.
    typedef enum logic [funct3_w-1:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_srl = 3'b101
    } funct3_e;

    // Upper 12 bits of the privileged SYSTEM instructions.
    localparam logic [funct12_w-1:0] funct12_ecall  = 12'h000;
    localparam logic [funct12_w-1:0] funct12_ebreak = 12'h001;
    localparam logic [funct12_w-1:0] funct12_wfi    = 12'h105;
    localparam logic [funct12_w-1:0] funct12_mret   = 12'h302;

    // Machine-mode trap causes.
    typedef enum logic [cause_w-1:0] {
        cause_illegal = 4'd2,
        cause_ebreak  = 4'd3,
        cause_m_ecall = 4'd11
    } cause_e;

endpackage

// ==== common/id_pipe_pkg.sv ====
package id_pipe_pkg;

    // Fetch to decode.
    typedef struct packed {
        logic                               valid;
        logic [31:1]                        pc;
        logic [rv_isa_pkg::ilen-1:0]        insn;
        logic                               trap;
        logic [rv_isa_pkg::cause_w-1:0]     cause;
    } if_id_t;

    // Decode to execute.
    typedef struct packed {
        logic                               valid;
        logic [31:1]                        pc;
        logic [rv_isa_pkg::ilen-1:0]        insn;
        logic                               use_rd;
        logic [rv_isa_pkg::xlen-1:0]        rs1_val;
        logic [rv_isa_pkg::xlen-1:0]        rs2_val;
        logic                               branch;
        logic                               branch_predict;
        logic                               trap;
        logic [rv_isa_pkg::cause_w-1:0]     cause;
    } id_ex_t;

    // Register write-back.
    typedef struct packed {
        logic                               we;
        logic [rv_isa_pkg::reg_idx_w-1:0]   rd;
        logic [rv_isa_pkg::xlen-1:0]        wdata;
    } wb_t;

    // Branch information sent back to fetch.
    typedef struct packed {
        logic                               is_xret;
        logic                               is_jump;
        logic                               is_branch;
        logic                               predict;
        logic [31:1]                        target;
        logic                               use_rs1;
    } branch_info_t;

endpackage

// ==== source/id_regfile.sv ====
`timescale 1ns/1ps

module id_regfile (
    input  logic                                clk,
    input  logic                                rst,
    input  id_pipe_pkg::wb_t                    wb,
    input  logic [rv_isa_pkg::reg_idx_w-1:0]    rs1_idx,
    input  logic [rv_isa_pkg::reg_idx_w-1:0]    rs2_idx,
    output logic [rv_isa_pkg::xlen-1:0]         rs1_val,
    output logic [rv_isa_pkg::xlen-1:0]         rs2_val
);

    // x1 to x31, x0 has no storage.
    logic [rv_isa_pkg::xlen-1:0] storage [1:31];

    // Combinational read, x0 reads as zero.
    assign rs1_val = (rs1_idx == '0) ? '0 : storage[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : storage[rs2_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                storage[i] <= '0;
            end
        end else if (wb.we && (wb.rd != '0)) begin
            storage[wb.rd] <= wb.wdata;
        end
    end

endmodule

// ==== id_decode/id_insn_decoder.sv ====
`timescale 1ns/1ps

module id_insn_decoder (
    input  logic [rv_isa_pkg::ilen-1:0] insn,
    output logic                        valid,
    output logic                        use_rd,
    output logic                        ecall,
    output logic                        ebreak
);

    rv_isa_pkg::opcode_e                    opcode;
    logic [rv_isa_pkg::funct3_w-1:0]        funct3;
    logic [rv_isa_pkg::funct12_w-1:0]       funct12;
    logic                                   sll_ok;
    logic                                   sr_ok;
    logic                                   is_priv;

    assign opcode  = rv_isa_pkg::opcode_e'(insn[6:2]);
    assign funct3  = insn[14:12];
    assign funct12 = insn[31:20];

    // Left shift and most R-type ops need a clear funct7.
    assign sll_ok = insn[31:25] == '0;
    // Right shift and add allow bit 30 only.
    assign sr_ok  = !insn[31] && (insn[29:25] == '0);

    // Privileged SYSTEM space, funct3 zero.
    assign is_priv = (opcode == rv_isa_pkg::op_system) && (funct3 == '0);
    assign ecall   = is_priv && (funct12 == rv_isa_pkg::funct12_ecall);
    assign ebreak  = is_priv && (funct12 == rv_isa_pkg::funct12_ebreak);

    always_comb begin
        valid = 1'b0;
        if (insn[1:0] == 2'b11) begin
            case (opcode)
                rv_isa_pkg::op_load: begin
                    // LB, LH, LW, LBU and LHU.
                    valid = (funct3 != 3'd3) && (funct3 < 3'd6);
                end
                rv_isa_pkg::op_store:    valid = funct3 < 3'd3;
                rv_isa_pkg::op_misc_mem: valid = funct3 < 3'd2;
                rv_isa_pkg::op_op_imm: begin
                    case (funct3)
                        rv_isa_pkg::alu_sll: valid = sll_ok;
                        rv_isa_pkg::alu_srl: valid = sr_ok;
                        default:             valid = 1'b1;
                    endcase
                end
                rv_isa_pkg::op_op: begin
                    if (insn[25]) begin
                        // M extension.
                        valid = insn[31:26] == '0;
                    end else if (funct3 == rv_isa_pkg::alu_add
                                 || funct3 == rv_isa_pkg::alu_srl) begin
                        valid = sr_ok;
                    end else begin
                        valid = sll_ok;
                    end
                end
                rv_isa_pkg::op_branch: valid = funct3[2:1] != 2'b01;
                rv_isa_pkg::op_jalr:   valid = funct3 == '0;
                rv_isa_pkg::op_lui,
                rv_isa_pkg::op_auipc,
                rv_isa_pkg::op_jal:    valid = 1'b1;
                rv_isa_pkg::op_system: begin
                    if (funct3 == '0) begin
                        valid = funct12 inside {rv_isa_pkg::funct12_ecall,
                                                rv_isa_pkg::funct12_ebreak,
                                                rv_isa_pkg::funct12_mret,
                                                rv_isa_pkg::funct12_wfi};
                    end else begin
                        // CSR access, funct3 4 is reserved.
                        valid = funct3 != 3'd4;
                    end
                end
                default: valid = 1'b0;
            endcase
        end
    end

    // Instructions that write rd.
    always_comb begin
        case (opcode)
            rv_isa_pkg::op_load,
            rv_isa_pkg::op_op_imm,
            rv_isa_pkg::op_auipc,
            rv_isa_pkg::op_op,
            rv_isa_pkg::op_lui,
            rv_isa_pkg::op_jalr,
            rv_isa_pkg::op_jal:    use_rd = 1'b1;
            rv_isa_pkg::op_system: use_rd = funct3 != '0;
            default:               use_rd = 1'b0;
        endcase
    end

endmodule

// ==== id_decode/id_branch_decoder.sv ====
`timescale 1ns/1ps

module id_branch_decoder (
    input  logic [rv_isa_pkg::ilen-1:0] insn,
    input  logic [31:1]                 pc,
    input  logic [rv_isa_pkg::xlen-1:0] rs1_val,
    output id_pipe_pkg::branch_info_t   info
);

    rv_isa_pkg::opcode_e            opcode;
    logic [rv_isa_pkg::xlen-1:0]    add_lhs;
    logic [rv_isa_pkg::xlen-1:0]    add_rhs;
    logic [rv_isa_pkg::xlen-1:0]    add_res;
    logic                           is_jump;
    logic                           is_branch;
    logic                           is_xret;
    logic                           use_rs1;

    assign opcode = rv_isa_pkg::opcode_e'(insn[6:2]);

    always_comb begin
        is_jump   = 1'b0;
        is_branch = 1'b0;
        is_xret   = 1'b0;
        use_rs1   = 1'b0;
        add_lhs   = {pc, 1'b0};
        add_rhs   = '0;
        case (opcode)
            rv_isa_pkg::op_jal: begin
                is_jump = 1'b1;
                // J-type immediate.
                add_rhs = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
            end
            rv_isa_pkg::op_jalr: begin
                is_jump = 1'b1;
                use_rs1 = 1'b1;
                add_lhs = rs1_val;
                add_rhs = {{20{insn[31]}}, insn[31:20]};
            end
            rv_isa_pkg::op_branch: begin
                is_branch = 1'b1;
                // B-type immediate.
                add_rhs = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
            end
            rv_isa_pkg::op_system: begin
                is_xret = (insn[14:12] == '0) && (insn[31:20] == rv_isa_pkg::funct12_mret);
            end
            default: ;
        endcase
    end

    assign add_res = add_lhs + add_rhs;

    assign info.is_xret   = is_xret;
    assign info.is_jump   = is_jump;
    assign info.is_branch = is_branch;
    // Backward branches have the sign bit set and are predicted taken.
    assign info.predict   = insn[31];
    assign info.target    = add_res[31:1];
    assign info.use_rs1   = use_rs1;

endmodule

// ==== source/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  id_pipe_pkg::if_id_t         d,
    input  id_pipe_pkg::wb_t            wb,
    input  logic                        stall,
    input  logic                        clear,
    input  logic                        fw_rs1_bt,
    input  logic [rv_isa_pkg::xlen-1:0] fw_val,
    output id_pipe_pkg::id_ex_t         q,
    output id_pipe_pkg::branch_info_t   br
);

    // Fetch to decode barrier.
    logic                               r_valid;
    logic                               r_trap;
    logic [rv_isa_pkg::ilen-1:0]        r_insn;
    logic [31:1]                        r_pc;
    logic [rv_isa_pkg::cause_w-1:0]     r_cause;

    logic [rv_isa_pkg::xlen-1:0]        rs1_val;
    logic [rv_isa_pkg::xlen-1:0]        rs2_val;
    logic [rv_isa_pkg::xlen-1:0]        bt_rs1;
    logic                               insn_valid;
    logic                               use_rd;
    logic                               ecall;
    logic                               ebreak;
    logic                               raise;
    logic [rv_isa_pkg::cause_w-1:0]     cause;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= 1'b0;
            r_trap  <= 1'b0;
            r_insn  <= '0;
        end else if (!stall) begin
            r_valid <= d.valid;
            r_trap  <= d.trap;
            r_insn  <= d.insn;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            r_pc    <= d.pc;
            r_cause <= d.cause;
        end
    end

    id_regfile regfile_inst (
        .clk     (clk),
        .rst     (rst),
        .wb      (wb),
        .rs1_idx (r_insn[19:15]),
        .rs2_idx (r_insn[24:20]),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    id_insn_decoder insn_decoder_inst (
        .insn   (r_insn),
        .valid  (insn_valid),
        .use_rd (use_rd),
        .ecall  (ecall),
        .ebreak (ebreak)
    );

    // Late RS1 from the forwarding path for JALR.
    assign bt_rs1 = fw_rs1_bt ? fw_val : rs1_val;

    id_branch_decoder branch_decoder_inst (
        .insn    (r_insn),
        .pc      (r_pc),
        .rs1_val (bt_rs1),
        .info    (br)
    );

    // Trap priority, an incoming trap wins.
    always_comb begin
        raise = 1'b1;
        if (r_trap) begin
            cause = r_cause;
        end else if (r_valid && !insn_valid) begin
            cause = rv_isa_pkg::cause_illegal;
        end else if (r_valid && ecall) begin
            cause = rv_isa_pkg::cause_m_ecall;
        end else if (r_valid && ebreak) begin
            cause = rv_isa_pkg::cause_ebreak;
        end else begin
            raise = 1'b0;
            cause = '0;
        end
    end

    assign q.valid          = !raise && r_valid && !clear;
    assign q.pc             = r_pc;
    assign q.insn           = r_insn;
    assign q.use_rd         = use_rd;
    assign q.rs1_val        = rs1_val;
    assign q.rs2_val        = rs2_val;
    assign q.branch         = br.is_branch;
    assign q.branch_predict = br.predict;
    assign q.trap           = raise && !clear;
    assign q.cause          = cause;

endmodule

// ==== sim/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;

    localparam int cmp_timeout = 8;

    logic                           clk;
    logic                           rst;
    id_pipe_pkg::if_id_t            d;
    id_pipe_pkg::wb_t               wb;
    logic                           stall;
    logic                           clear;
    logic                           fw_rs1_bt;
    logic [rv_isa_pkg::xlen-1:0]    fw_val;
    id_pipe_pkg::id_ex_t            q;
    id_pipe_pkg::branch_info_t      br;

    logic [31:0]                    lfsr;
    logic [rv_isa_pkg::xlen-1:0]    model_regs [0:31];
    id_pipe_pkg::id_ex_t            exp_q;
    id_pipe_pkg::branch_info_t      exp_br;
    int                             cmp_req;
    int                             cmp_ack = 0;

    id_stage id_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .d         (d),
        .wb        (wb),
        .stall     (stall),
        .clear     (clear),
        .fw_rs1_bt (fw_rs1_bt),
        .fw_val    (fw_val),
        .q         (q),
        .br        (br)
    );

    always #2 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic id_pipe_pkg::id_ex_t ref_decode(input id_pipe_pkg::if_id_t item,
                                                        input logic clr);
        id_pipe_pkg::id_ex_t r;
        logic [31:0]         i;
        logic [4:0]          opc;
        logic [2:0]          f3;
        logic [11:0]         f12;
        logic                ok;
        logic                sl;
        logic                sr;
        logic                sys0;
        logic                raise;
        r    = '0;
        i    = item.insn;
        opc  = i[6:2];
        f3   = i[14:12];
        f12  = i[31:20];
        sl   = i[31:25] == 7'd0;
        sr   = !i[31] && (i[29:25] == 5'd0);
        sys0 = (opc == rv_isa_pkg::op_system) && (f3 == 3'd0);
        ok   = 1'b0;
        if (i[1:0] == 2'b11) begin
            case (opc)
                rv_isa_pkg::op_load:
                    ok = (f3 <= 3'd2) || (f3 == 3'd4) || (f3 == 3'd5);
                rv_isa_pkg::op_store:    ok = f3 < 3'd3;
                rv_isa_pkg::op_misc_mem: ok = f3 < 3'd2;
                rv_isa_pkg::op_op_imm:
                    ok = (f3 == 3'd1) ? sl : (f3 == 3'd5) ? sr : 1'b1;
                rv_isa_pkg::op_op:
                    ok = i[25] ? (i[31:26] == 6'd0) : ((f3 == 3'd0) || (f3 == 3'd5)) ? sr : sl;
                rv_isa_pkg::op_branch:   ok = (f3 != 3'd2) && (f3 != 3'd3);
                rv_isa_pkg::op_jalr:     ok = f3 == 3'd0;
                rv_isa_pkg::op_lui,
                rv_isa_pkg::op_auipc,
                rv_isa_pkg::op_jal:      ok = 1'b1;
                rv_isa_pkg::op_system:
                    ok = sys0 ? (f12 == 12'h000 || f12 == 12'h001 || f12 == 12'h302
                                 || f12 == 12'h105) : (f3 != 3'd4);
                default:                 ok = 1'b0;
            endcase
        end
        case (opc)
            rv_isa_pkg::op_load, rv_isa_pkg::op_op_imm, rv_isa_pkg::op_auipc,
            rv_isa_pkg::op_op, rv_isa_pkg::op_lui, rv_isa_pkg::op_jalr,
            rv_isa_pkg::op_jal:    r.use_rd = 1'b1;
            rv_isa_pkg::op_system: r.use_rd = f3 != 3'd0;
            default:               r.use_rd = 1'b0;
        endcase
        // Incoming trap first, then illegal, ECALL and EBREAK.
        raise = 1'b1;
        if (item.trap) begin
            r.cause = item.cause;
        end else if (item.valid && !ok) begin
            r.cause = rv_isa_pkg::cause_illegal;
        end else if (item.valid && sys0 && f12 == 12'h000) begin
            r.cause = rv_isa_pkg::cause_m_ecall;
        end else if (item.valid && sys0 && f12 == 12'h001) begin
            r.cause = rv_isa_pkg::cause_ebreak;
        end else begin
            raise = 1'b0;
        end
        r.valid          = !raise && item.valid && !clr;
        r.trap           = raise && !clr;
        r.pc             = item.pc;
        r.insn           = i;
        r.rs1_val        = model_regs[i[19:15]];
        r.rs2_val        = model_regs[i[24:20]];
        r.branch         = opc == rv_isa_pkg::op_branch;
        r.branch_predict = i[31];
        return r;
    endfunction

    function automatic id_pipe_pkg::branch_info_t ref_branch(input logic [31:0] i,
            input logic [31:1] pc, input logic [31:0] rs1);
        id_pipe_pkg::branch_info_t r;
        logic [31:0]               base;
        logic [31:0]               imm;
        logic [31:0]               sum;
        r    = '0;
        base = {pc, 1'b0};
        imm  = '0;
        case (i[6:2])
            rv_isa_pkg::op_jal: begin
                r.is_jump = 1'b1;
                imm       = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            end
            rv_isa_pkg::op_jalr: begin
                r.is_jump = 1'b1;
                r.use_rs1 = 1'b1;
                base      = rs1;
                imm       = {{20{i[31]}}, i[31:20]};
            end
            rv_isa_pkg::op_branch: begin
                r.is_branch = 1'b1;
                imm         = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            end
            rv_isa_pkg::op_system: r.is_xret = (i[14:12] == 3'd0) && (i[31:20] == 12'h302);
            default: ;
        endcase
        sum       = base + imm;
        r.target  = sum[31:1];
        r.predict = i[31];
        return r;
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_id_ex(input id_pipe_pkg::id_ex_t got, input id_pipe_pkg::id_ex_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: q differs for insn %h", $time, exp.insn);
            $display("  got      %h", got);
            $display("  expected %h", exp);
            abort_run();
        end
    endtask

    task automatic check_branch(input id_pipe_pkg::branch_info_t got,
                                input id_pipe_pkg::branch_info_t exp);
        logic tgt_bad;
        // The target only means something for jumps and branches.
        tgt_bad = (exp.is_jump || exp.is_branch) && (got.target !== exp.target);
        if (tgt_bad || got.is_xret !== exp.is_xret || got.is_jump !== exp.is_jump
            || got.is_branch !== exp.is_branch || got.predict !== exp.predict
            || got.use_rs1 !== exp.use_rs1) begin
            $display("Mismatch at %0t: br got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    // Outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (cmp_req != cmp_ack) begin
            check_id_ex(q, exp_q);
            check_branch(br, exp_br);
            cmp_ack = cmp_req;
        end
    end

    task automatic wait_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
        end
    endtask

    // Called just after the edge that latched item.
    task automatic expect_now(input id_pipe_pkg::if_id_t item, input logic clr);
        logic [31:0] bt_rs1;
        int          n;
        bt_rs1  = fw_rs1_bt ? fw_val : model_regs[item.insn[19:15]];
        exp_q   = ref_decode(item, clr);
        exp_br  = ref_branch(item.insn, item.pc, bt_rs1);
        cmp_req++;
        n = 0;
        while (cmp_ack != cmp_req) begin
            if (n == cmp_timeout) begin
                $display("Timeout at %0t: the compare process never ran", $time);
                abort_run();
            end
            @(posedge clk);
            n++;
        end
    endtask

    task automatic present(input id_pipe_pkg::if_id_t item, input id_pipe_pkg::wb_t wbi,
                           input logic fw_en, input logic [31:0] fwv);
        d         <= item;
        wb        <= wbi;
        stall     <= 1'b0;
        fw_rs1_bt <= fw_en;
        fw_val    <= fwv;
        @(posedge clk);
        if (wbi.we && wbi.rd != 5'd0) begin
            model_regs[wbi.rd] = wbi.wdata;
        end
        wb <= '0;
        expect_now(item, 1'b0);
    endtask

    function automatic logic [4:0] pick_opcode(input logic [3:0] idx);
        case (idx)
            4'd0:           return rv_isa_pkg::op_load;
            4'd1:           return rv_isa_pkg::op_misc_mem;
            4'd2, 4'd11:    return rv_isa_pkg::op_op_imm;
            4'd3:           return rv_isa_pkg::op_auipc;
            4'd4:           return rv_isa_pkg::op_store;
            4'd5, 4'd12:    return rv_isa_pkg::op_op;
            4'd6:           return rv_isa_pkg::op_lui;
            4'd7, 4'd13:    return rv_isa_pkg::op_branch;
            4'd8:           return rv_isa_pkg::op_jalr;
            4'd9:           return rv_isa_pkg::op_jal;
            default:        return rv_isa_pkg::op_system;
        endcase
    endfunction

    function automatic id_pipe_pkg::if_id_t rand_item(input logic biased);
        id_pipe_pkg::if_id_t r;
        logic [31:0]         t;
        r      = '0;
        r.insn = rand_bits(32);
        t      = rand_bits(32);
        r.pc   = t[31:1];
        t      = rand_bits(3);
        r.valid = t[2:0] != 3'd0;
        t      = rand_bits(3);
        r.trap = t[2:0] == 3'd0;
        t      = rand_bits(4);
        r.cause = t[3:0];
        if (biased) begin
            t = rand_bits(4);
            r.insn[6:0] = {pick_opcode(t[3:0]), 2'b11};
            // Mostly legal funct7 values including M and SUB/SRA.
            t = rand_bits(3);
            if (t[0]) begin
                r.insn[31:25] = {1'b0, t[1], 4'd0, t[2]};
            end
            t = rand_bits(3);
            if (r.insn[6:2] == rv_isa_pkg::op_system && t[0]) begin
                r.insn[14:12] = 3'd0;
                case (t[2:1])
                    2'd0:    r.insn[31:20] = 12'h000;
                    2'd1:    r.insn[31:20] = 12'h001;
                    2'd2:    r.insn[31:20] = 12'h302;
                    default: r.insn[31:20] = 12'h105;
                endcase
            end
        end
        return r;
    endfunction

    initial begin
        id_pipe_pkg::if_id_t item;
        id_pipe_pkg::if_id_t nxt;
        id_pipe_pkg::wb_t    wbi;
        logic [31:0]         t;
        logic                fw_en;
        clk         = 1'b0;
        rst         = 1'b1;
        d           = '0;
        wb          = '0;
        stall       = 1'b0;
        clear       = 1'b0;
        fw_rs1_bt   = 1'b0;
        fw_val      = '0;
        lfsr        = 32'ha02b_3484;
        cmp_req     = 0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        wait_cycles(2);
        rst  <= 1'b0;
        item = '0;
        expect_now(item, 1'b0);

        // Every register reads zero after reset.
        for (int k = 1; k < 32; k++) begin
            item       = '0;
            item.valid = 1'b1;
            item.insn  = {7'd0, k[4:0], k[4:0], 3'd0, 5'd0, 7'b0110011};
            present(item, '0, 1'b0, '0);
        end

        // Write-back to random registers including x0, then a read through an ADD.
        for (int k = 0; k < 48; k++) begin
            t         = rand_bits(5);
            wbi.rd    = (k == 0) ? 5'd0 : t[4:0];
            t         = rand_bits(3);
            wbi.we    = (k == 0) || (t[2:0] != 3'd0);
            wbi.wdata = rand_bits(32);
            t         = rand_bits(5);
            item       = '0;
            item.valid = 1'b1;
            item.insn  = {7'd0, t[4:0], wbi.rd, 3'd0, 5'd1, 7'b0110011};
            present(item, wbi, 1'b0, '0);
        end

        for (int k = 0; k < 400; k++) begin
            item = rand_item(k[0]);
            present(item, '0, 1'b0, '0);
        end

        // Jumps, branches and MRET, with the JALR forwarding path.
        for (int k = 0; k < 80; k++) begin
            item       = rand_item(1'b0);
            item.valid = 1'b1;
            item.trap  = 1'b0;
            t          = rand_bits(2);
            case (t[1:0])
                2'd0:    item.insn[6:0] = {rv_isa_pkg::op_jal, 2'b11};
                2'd1:    item.insn[6:0] = {rv_isa_pkg::op_jalr, 2'b11};
                2'd2:    item.insn[6:0] = {rv_isa_pkg::op_branch, 2'b11};
                default: item.insn = {12'h302, 5'd0, 3'd0, 5'd0, 7'b1110011};
            endcase
            t     = rand_bits(1);
            fw_en = t[0];
            present(item, '0, fw_en, rand_bits(32));
        end

        // Stall holds q while d keeps changing.
        for (int k = 0; k < 6; k++) begin
            item = rand_item(1'b1);
            present(item, '0, 1'b0, '0);
            stall <= 1'b1;
            for (int s = 0; s < 3; s++) begin
                nxt = rand_item(1'b1);
                d   <= nxt;
                expect_now(item, 1'b0);
            end
            stall <= 1'b0;
            expect_now(item, 1'b0);
            expect_now(nxt, 1'b0);
        end

        // Clear masks valid and trap in the same cycle.
        for (int k = 0; k < 20; k++) begin
            item       = rand_item(1'b1);
            item.valid = 1'b1;
            item.trap  = k[0];
            present(item, '0, 1'b0, '0);
            clear <= 1'b1;
            expect_now(item, 1'b1);
            clear <= 1'b0;
            expect_now(item, 1'b0);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
common/rv_isa_pkg.sv
common/id_pipe_pkg.sv
source/id_regfile.sv
id_decode/id_insn_decoder.sv
id_decode/id_branch_decoder.sv
source/id_stage.sv
sim/tb_id_stage.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_id_stage
DUT_TOP   := id_stage
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
